/* hdl/mf2_pkg.sv */
// Multiface Two shared definitions
// Bus widths, paging states and fixed port and vector constants

package mf2_pkg;

	////////////////////
	// Bus and storage widths
	////////////////////

	// Z80 address and data bus
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;

	// Word address into the 8 KB Multiface RAM
	typedef logic [12:0] mf2_addr_t;

	// Gate array pen number with bit 4 for the border
	typedef logic [4:0] pen_index_t;

	// CRTC register number
	typedef logic [3:0] crtc_reg_t;

	////////////////////
	// Paging machine
	////////////////////

	typedef enum logic [1:0] {
		MF2_IDLE,
		MF2_NMI_PENDING,
		MF2_PAGED
	} mf2_state_t;

	////////////////////
	// Fixed addresses
	////////////////////

	// M1 fetch addresses that page in and hide the device
	localparam cpu_addr_t NMI_VECTOR  = 16'h0066;
	localparam cpu_addr_t HIDE_VECTOR = 16'h0065;

	// Base of ports FEE8..FEEB where bit 1 selects page out
	localparam cpu_addr_t CTRL_PORT_BASE = 16'hFEE8;

	// High address bytes of the shadowed hardware ports
	localparam logic [7:0] GA_PORT        = 8'h7F;
	localparam logic [7:0] CRTC_SEL_PORT  = 8'hBC;
	localparam logic [7:0] CRTC_DATA_PORT = 8'hBD;
	localparam logic [7:0] PPI_PORT       = 8'hF7;
	localparam logic [7:0] ROM_SEL_PORT   = 8'hDF;

endpackage

/* hdl/z80_bus_events.sv */
// Z80 bus event detector
// Turns the io_wr, m1 and freeze levels into one-cycle rising-edge strobes
// with no added latency

module z80_bus_events (
	input  logic clk_sys,
	input  logic reset,

	// Bus levels
	input  logic io_wr,
	input  logic m1,
	input  logic freeze,

	// Rising-edge strobes
	output logic io_wr_stb,
	output logic m1_stb,
	output logic freeze_stb
);

	localparam int NUM_EVENTS = 3;

	logic [NUM_EVENTS-1:0] levels;
	logic [NUM_EVENTS-1:0] levels_q;
	logic [NUM_EVENTS-1:0] edges;

	// Bit order is freeze, m1, io_wr
	assign levels = {freeze, m1, io_wr};

	////////////////////
	// Delayed copies
	////////////////////

	// Cleared at reset so a level held through reset gives no strobe
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			levels_q <= '0;
		end else begin
			levels_q <= levels;
		end
	end

	////////////////////
	// Edge strobes
	////////////////////

	// High in the first cycle the level is seen high
	assign edges = levels & ~levels_q;

	assign io_wr_stb  = edges[0];
	assign m1_stb     = edges[1];
	assign freeze_stb = edges[2];

endmodule

/* hdl/mf2_control.sv */
// Multiface Two paging control
// FSM for NMI entry and paging, hidden flag, control ports FEE8/FEEA
// and the ROM/RAM window decode

module mf2_control (
	input  logic             clk_sys,
	input  logic             reset,

	// Bus event strobes
	input  logic             m1_stb,
	input  logic             io_wr_stb,
	input  logic             freeze_stb,
	input  mf2_pkg::cpu_addr_t addr,

	// Mode levels
	input  logic             mf2_disabled,
	input  logic             mf2_hidden_mode,

	output logic             nmi,
	output logic             paged,
	output logic             ram_en,
	output logic             rom_en
);

	import mf2_pkg::*;

	mf2_state_t state;
	logic       hidden;
	logic       ctrl_port_hit;
	logic       page_in_ok;

	// FEE8..FEEB
	assign ctrl_port_hit = io_wr_stb && (addr[15:2] == CTRL_PORT_BASE[15:2]);

	// Page in only on FEE8 and only when visible
	assign page_in_ok = !addr[1] && !hidden && !mf2_disabled;

	////////////////////
	// Paging FSM
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state  <= MF2_IDLE;
			hidden <= mf2_disabled | mf2_hidden_mode;
		end else begin
			case (state)
				MF2_IDLE: begin
					// Freeze button only while the window is out
					if (freeze_stb && !mf2_disabled) begin
						state <= MF2_NMI_PENDING;
					end
				end
				MF2_NMI_PENDING: begin
					// CPU takes the NMI and the window comes in
					if (m1_stb && addr == NMI_VECTOR) begin
						state  <= MF2_PAGED;
						hidden <= 1'b0;
					end
				end
				MF2_PAGED: begin
					// Software hides the device on its way out
					if (m1_stb && addr == HIDE_VECTOR) begin
						hidden <= 1'b1;
					end
				end
				default: begin
					state <= MF2_IDLE;
				end
			endcase

			// Control port write overrides the above
			if (ctrl_port_hit) begin
				if (page_in_ok) begin
					state <= MF2_PAGED;
				end else if (addr[1] && state == MF2_PAGED) begin
					state <= MF2_IDLE;
				end
			end
		end
	end

	assign nmi   = (state == MF2_NMI_PENDING);
	assign paged = (state == MF2_PAGED);

	////////////////////
	// Window decode
	////////////////////

	// ROM at 0000-1FFF, RAM at 2000-3FFF
	assign rom_en = paged && (addr[15:13] == 3'b000);
	assign ram_en = paged && (addr[15:13] == 3'b001);

endmodule

/* hdl/mf2_shadow_map.sv */
// Multiface Two hardware shadow map
// Tracks pen and CRTC register selection and maps writes to the gate array,
// CRTC, 8255 and upper ROM ports onto fixed shadow RAM addresses

module mf2_shadow_map (
	input  logic               clk_sys,
	input  logic               reset,

	input  logic               io_wr_stb,
	input  mf2_pkg::cpu_addr_t addr,
	input  mf2_pkg::cpu_data_t wdata,

	// Shadow store request, same cycle as the strobe
	output logic               store_valid,
	output mf2_pkg::mf2_addr_t store_addr,
	output mf2_pkg::cpu_data_t store_data
);

	import mf2_pkg::*;

	pen_index_t pen_index;
	crtc_reg_t  crtc_reg;
	logic       pen_select;
	logic       crtc_select;

	assign pen_select  = (addr[15:8] == GA_PORT) && (wdata[7:6] == 2'b00);
	assign crtc_select = (addr[15:8] == CRTC_SEL_PORT);

	////////////////////
	// Selection tracking
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pen_index <= '0;
			crtc_reg  <= '0;
		end else if (io_wr_stb) begin
			if (pen_select) begin
				pen_index <= wdata[4:0];
			end
			if (crtc_select) begin
				crtc_reg <= wdata[3:0];
			end
		end
	end

	////////////////////
	// Address map
	////////////////////

	// Zero means the port is not shadowed
	always_comb begin
		casez ({addr[15:8], wdata[7:6]})
			{GA_PORT, 2'b00}: store_addr = 13'h1FCF;
			{GA_PORT, 2'b01}: begin
				// Border colour lives apart from the 16 inks
				if (pen_index[4]) begin
					store_addr = 13'h1FDF;
				end else begin
					store_addr = {9'h1F9, pen_index[3:0]};
				end
			end
			{GA_PORT, 2'b10}:         store_addr = 13'h1FEF;
			{GA_PORT, 2'b11}:         store_addr = 13'h1FFF;
			{CRTC_SEL_PORT, 2'b??}:   store_addr = 13'h1CFF;
			{CRTC_DATA_PORT, 2'b??}:  store_addr = {9'h1DB, crtc_reg};
			{PPI_PORT, 2'b??}:        store_addr = 13'h17FF;
			{ROM_SEL_PORT, 2'b??}:    store_addr = 13'h1AAC;
			default:                  store_addr = '0;
		endcase
	end

	assign store_valid = io_wr_stb && (store_addr != '0);
	assign store_data  = wdata;

endmodule

/* hdl/mf2_ram_port.sv */
// Multiface Two RAM port
// 8 KB RAM shared by shadow stores, CPU window writes and CPU reads,
// with the read data gated onto the bus

module mf2_ram_port (
	input  logic               clk_sys,
	input  logic               reset,

	// Shadow store request
	input  logic               store_valid,
	input  mf2_pkg::mf2_addr_t store_addr,
	input  mf2_pkg::cpu_data_t store_data,

	// CPU memory access
	input  logic               mem_wr,
	input  logic               mem_rd,
	input  logic               ram_en,
	input  mf2_pkg::cpu_addr_t addr,
	input  mf2_pkg::cpu_data_t wdata,

	output mf2_pkg::cpu_data_t rdata
);

	import mf2_pkg::*;

	localparam int RAM_DEPTH = 8192;

	cpu_data_t mem [RAM_DEPTH];

	mf2_addr_t ram_addr;
	cpu_data_t ram_wdata;
	logic      ram_we;
	cpu_data_t ram_out;

	////////////////////
	// Access arbitration
	////////////////////

	// Shadow store wins over a CPU window write
	always_ff @(posedge clk_sys) begin
		if (store_valid) begin
			ram_addr  <= store_addr;
			ram_wdata <= store_data;
		end else begin
			ram_addr  <= addr[12:0];
			ram_wdata <= wdata;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ram_we <= 1'b0;
		end else begin
			ram_we <= store_valid || (mem_wr && ram_en);
		end
	end

	////////////////////
	// RAM array
	////////////////////

	// Write-through to the output register
	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			mem[ram_addr] <= ram_wdata;
			ram_out       <= ram_wdata;
		end else begin
			ram_out <= mem[ram_addr];
		end
	end

	// Idle bus reads FF
	assign rdata = (ram_en && mem_rd) ? ram_out : 8'hFF;

endmodule

/* hdl/mf2_top.sv */
// Multiface Two expansion top level
// Bus event detection, paging control, hardware shadowing and the 8 KB RAM

module mf2_top (
	input  logic               clk_sys,
	input  logic               reset,

	// CPU bus
	input  mf2_pkg::cpu_addr_t addr,
	input  mf2_pkg::cpu_data_t wdata,
	input  logic               io_wr,
	input  logic               m1,
	input  logic               mem_rd,
	input  logic               mem_wr,

	// Button and mode levels
	input  logic               freeze,
	input  logic               mf2_disabled,
	input  logic               mf2_hidden_mode,

	output logic               nmi,
	output logic               rom_en,
	output mf2_pkg::cpu_data_t rdata
);

	import mf2_pkg::*;

	logic      io_wr_stb;
	logic      m1_stb;
	logic      freeze_stb;
	logic      ram_en;
	logic      store_valid;
	mf2_addr_t store_addr;
	cpu_data_t store_data;

	////////////////////
	// Input side
	////////////////////

	z80_bus_events u_events (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.io_wr      (io_wr),
		.m1         (m1),
		.freeze     (freeze),
		.io_wr_stb  (io_wr_stb),
		.m1_stb     (m1_stb),
		.freeze_stb (freeze_stb)
	);

	////////////////////
	// Paging and shadowing
	////////////////////

	mf2_control u_control (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.m1_stb          (m1_stb),
		.io_wr_stb       (io_wr_stb),
		.freeze_stb      (freeze_stb),
		.addr            (addr),
		.mf2_disabled    (mf2_disabled),
		.mf2_hidden_mode (mf2_hidden_mode),
		.nmi             (nmi),
		.paged           (),
		.ram_en          (ram_en),
		.rom_en          (rom_en)
	);

	mf2_shadow_map u_shadow (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.io_wr_stb   (io_wr_stb),
		.addr        (addr),
		.wdata       (wdata),
		.store_valid (store_valid),
		.store_addr  (store_addr),
		.store_data  (store_data)
	);

	////////////////////
	// Output side
	////////////////////

	mf2_ram_port u_ram (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.store_valid (store_valid),
		.store_addr  (store_addr),
		.store_data  (store_data),
		.mem_wr      (mem_wr),
		.mem_rd      (mem_rd),
		.ram_en      (ram_en),
		.addr        (addr),
		.wdata       (wdata),
		.rdata       (rdata)
	);

endmodule

/* verification/mf2_tb_tasks.svh */
// Multiface Two testbench bus-cycle tasks
// Drive and sample points, CPU bus cycles, bounded waits and the
// expected shadow address taken from the port map
`ifndef MF2_TB_TASKS_SVH
`define MF2_TB_TASKS_SVH

localparam int DRIVE_DELAY = 10;
localparam int WAIT_LIMIT  = 8;

task automatic stop_with_failure();
	$display("SOME TESTS FAILED");
	$fatal(1);
endtask

task automatic report_mismatch(input string test_name, input logic [15:0] expected,
		input logic [15:0] actual);
	$display("ERROR %s expected %0h actual %0h", test_name, expected, actual);
	stop_with_failure();
endtask

task automatic report_problem(input string what);
	$display("Failure: %s", what);
	stop_with_failure();
endtask

task automatic check_bit(input string test_name, input logic expected, input logic actual);
	assert (actual === expected)
		else report_mismatch(test_name, {15'h0000, expected}, {15'h0000, actual});
endtask

task automatic check_byte(input string test_name, input logic [7:0] expected,
		input logic [7:0] actual);
	assert (actual === expected)
		else report_mismatch(test_name, {8'h00, expected}, {8'h00, actual});
endtask

// Inputs change shortly after the rising edge and outputs are read at the falling edge
task automatic next_drive();
	@(posedge clk_sys);
	#DRIVE_DELAY;
endtask

task automatic next_sample();
	@(negedge clk_sys);
endtask

////////////////////
// Bus cycles
////////////////////

task automatic io_write(input logic [15:0] a, input logic [7:0] d);
	next_drive();
	addr  = a;
	wdata = d;
	io_wr = 1'b1;
	next_drive();
	io_wr = 1'b0;
endtask

task automatic m1_fetch(input logic [15:0] a);
	next_drive();
	addr = a;
	m1   = 1'b1;
	next_drive();
	m1 = 1'b0;
endtask

task automatic mem_write(input logic [15:0] a, input logic [7:0] d);
	next_drive();
	addr   = a;
	wdata  = d;
	mem_wr = 1'b1;
	next_drive();
	mem_wr = 1'b0;
endtask

// Read data settles two edges after the address
task automatic mem_read(input logic [15:0] a, output logic [7:0] d);
	next_drive();
	addr   = a;
	mem_rd = 1'b1;
	repeat (2) next_drive();
	next_sample();
	d = rdata;
	next_drive();
	mem_rd = 1'b0;
endtask

task automatic press_freeze();
	next_drive();
	freeze = 1'b1;
	next_drive();
	freeze = 1'b0;
endtask

////////////////////
// Bounded waits
////////////////////

task automatic wait_rom_en(input logic [15:0] probe, input logic level, input string test_name);
	int cycles;
	cycles = 0;
	next_drive();
	addr = probe;
	next_sample();
	while (rom_en !== level && cycles < WAIT_LIMIT) begin
		cycles++;
		next_sample();
	end
	if (rom_en !== level)
		report_problem($sformatf("%s: rom_en never reached %0b at address %h",
			test_name, level, probe));
endtask

task automatic wait_nmi(input logic level, input string test_name);
	int cycles;
	cycles = 0;
	next_sample();
	while (nmi !== level && cycles < WAIT_LIMIT) begin
		cycles++;
		next_sample();
	end
	if (nmi !== level)
		report_problem($sformatf("%s: nmi never reached %0b", test_name, level));
endtask

// Neither nmi nor the ROM window may come up
task automatic expect_quiet(input logic [15:0] probe, input int n, input string test_name);
	next_drive();
	addr = probe;
	repeat (n) begin
		next_sample();
		check_bit({test_name, "_nmi"}, 1'b0, nmi);
		check_bit({test_name, "_rom_en"}, 1'b0, rom_en);
	end
endtask

// CPU address inside the 2000h window where a port write is shadowed
function automatic logic [15:0] shadow_addr(input logic [7:0] port_hi, input logic [7:0] d,
		input logic [4:0] pen, input logic [3:0] reg_num);
	logic [15:0] offset;
	offset = 16'h0000;
	if (port_hi == 8'h7F) begin
		case (d[7:6])
			2'b00: offset = 16'h1FCF;
			2'b01: offset = (pen >= 5'd16) ? 16'h1FDF : 16'h1F90 + {11'd0, pen};
			2'b10: offset = 16'h1FEF;
			default: offset = 16'h1FFF;
		endcase
	end else if (port_hi == 8'hBC) begin
		offset = 16'h1CFF;
	end else if (port_hi == 8'hBD) begin
		offset = 16'h1DB0 + {12'd0, reg_num};
	end
	return 16'h2000 + offset;
endfunction

`endif

/* verification/mf2_tb.sv */
// Multiface Two testbench
// Drives CPU bus cycles into the expansion and checks NMI entry, paging,
// window RAM, hardware shadowing and the hide and control ports

module mf2_tb;

	logic        clk_sys;
	logic        reset;
	logic [15:0] addr;
	logic [7:0]  wdata;
	logic        io_wr;
	logic        m1;
	logic        mem_rd;
	logic        mem_wr;
	logic        freeze;
	logic        mf2_disabled;
	logic        mf2_hidden_mode;
	logic        nmi;
	logic        rom_en;
	logic [7:0]  rdata;

	integer      seed;

	mf2_top dut (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.addr            (addr),
		.wdata           (wdata),
		.io_wr           (io_wr),
		.m1              (m1),
		.mem_rd          (mem_rd),
		.mem_wr          (mem_wr),
		.freeze          (freeze),
		.mf2_disabled    (mf2_disabled),
		.mf2_hidden_mode (mf2_hidden_mode),
		.nmi             (nmi),
		.rom_en          (rom_en),
		.rdata           (rdata)
	);

	`include "mf2_tb_tasks.svh"

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	////////////////////
	// Bus properties
	////////////////////

	// Reads outside the RAM window see FF on the data bus
	outside_window_ff: assert property (@(posedge clk_sys) disable iff (reset)
		mem_rd && (addr[15:13] != 3'b001) |-> rdata == 8'hFF)
		else report_mismatch("outside_window_ff", 16'h00FF, {8'h00, $sampled(rdata)});

	nmi_after_freeze: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(nmi) |-> $past(freeze))
		else report_problem("nmi rose without a freeze press in the cycle before");

	initial begin
		logic [31:0] rand_word;
		logic [15:0] a;
		logic [7:0]  data;
		logic [7:0]  got;
		logic [3:0]  reg_num;
		logic [3:0]  pen;
		logic [7:0]  colour;

		seed            = 32'h54c9dc72;
		reset           = 1'b1;
		addr            = 16'h0000;
		wdata           = 8'h00;
		io_wr           = 1'b0;
		m1              = 1'b0;
		mem_rd          = 1'b0;
		mem_wr          = 1'b0;
		freeze          = 1'b0;
		mf2_disabled    = 1'b0;
		mf2_hidden_mode = 1'b0;
		repeat (3) @(posedge clk_sys);
		#DRIVE_DELAY;
		reset = 1'b0;

		// After reset
		next_sample();
		check_bit("reset_nmi", 1'b0, nmi);
		check_bit("reset_rom_en", 1'b0, rom_en);
		mem_read(16'h2000, got);
		check_byte("reset_rdata", 8'hFF, got);

		// NMI entry with nmi one edge after the press
		press_freeze();
		next_sample();
		check_bit("nmi_raise", 1'b1, nmi);
		m1_fetch(16'h0066);
		next_sample();
		check_bit("nmi_taken", 1'b0, nmi);
		wait_rom_en(16'h0100, 1'b1, "rom_window_in");
		next_drive();
		addr = 16'h4000;
		next_sample();
		check_bit("rom_window_edge", 1'b0, rom_en);

		// Disabled device ignores the button
		io_write(16'hFEEA, 8'h00);
		wait_rom_en(16'h0100, 1'b0, "page_out");
		next_drive();
		mf2_disabled = 1'b1;
		press_freeze();
		expect_quiet(16'h0100, 4, "disabled_freeze");
		next_drive();
		mf2_disabled = 1'b0;
		io_write(16'hFEE8, 8'h00);
		wait_rom_en(16'h0100, 1'b1, "port_page_in");

		// Window RAM
		for (int i = 0; i < 4; i++) begin
			rand_word = $random(seed);
			a         = 16'h2000 | {3'b000, rand_word[12:0]};
			data      = rand_word[23:16];
			mem_write(a, data);
			mem_read(a, got);
			check_byte("window_ram", data, got);
		end
		mem_read(16'h4000, got);
		check_byte("outside_window", 8'hFF, got);

		// CRTC and gate array shadow stores
		rand_word = $random(seed);
		reg_num   = rand_word[3:0];
		data      = rand_word[15:8];
		pen       = rand_word[19:16];
		colour    = {2'b01, rand_word[29:24]};
		io_write(16'hBC00, {4'h0, reg_num});
		io_write(16'hBD00, data);
		mem_read(shadow_addr(8'hBC, {4'h0, reg_num}, 5'd0, reg_num), got);
		check_byte("crtc_select_shadow", {4'h0, reg_num}, got);
		mem_read(shadow_addr(8'hBD, data, 5'd0, reg_num), got);
		check_byte("crtc_data_shadow", data, got);
		io_write(16'h7F00, {4'h0, pen});
		io_write(16'h7F40, colour);
		mem_read(shadow_addr(8'h7F, colour, {1'b0, pen}, 4'h0), got);
		check_byte("pen_colour_shadow", colour, got);

		// Hidden device ignores FEE8
		m1_fetch(16'h0065);
		io_write(16'hFEEA, 8'h00);
		wait_rom_en(16'h0100, 1'b0, "hide_page_out");
		io_write(16'hFEE8, 8'h00);
		expect_quiet(16'h0100, 4, "hidden_page_in");

		// New NMI entry makes the device visible again
		press_freeze();
		wait_nmi(1'b1, "nmi_reentry");
		m1_fetch(16'h0066);
		wait_rom_en(16'h0100, 1'b1, "reentry_paged");
		io_write(16'hFEEA, 8'h00);
		wait_rom_en(16'h0100, 1'b0, "reentry_page_out");
		io_write(16'hFEE8, 8'h00);
		wait_rom_en(16'h0100, 1'b1, "visible_page_in");

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* files.f */
+incdir+verification
hdl/mf2_pkg.sv
hdl/z80_bus_events.sv
hdl/mf2_control.sv
hdl/mf2_shadow_map.sv
hdl/mf2_ram_port.sv
hdl/mf2_top.sv
verification/mf2_tb.sv

/* Makefile */
# Verilator build and run for the Multiface Two testbench
# Override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= mf2_tb
FILELIST  ?= files.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides pass or fail
run: compile
	$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
